// File: tb.f
hdl/cache_types.sv
hdl/ff_array_rw.sv
hdl/plru.sv
hdl/way_lookup.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
tests/cache_mem_model.sv
tests/tb_cache.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_cache -f tb.f
out=$(./obj_dir/Vtb_cache) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"

// File: tests/tb_cache.sv
module tb_cache;

  logic        clk;
  logic        rst_n;
  logic        cpu_cyc, cpu_stb, cpu_we, cpu_ack;
  logic [31:0] cpu_adr, cpu_dat_w, cpu_dat_r;
  logic        mem_cyc, mem_stb, mem_we, mem_ack;
  logic [31:0] mem_adr, mem_dat_w, mem_dat_r;

  logic        req_new;     // First cycle of a request
  logic        expect_hit;  // Read hit predicted by the model
  logic [31:0] shadow [256];
  logic [31:0] exp_word;
  logic [31:0] lfsr;
  int          errors;
  int          tests;

  // Reference cache contents and tree bits
  logic [cache_types::TAG_BITS-1:0] ref_tag [cache_types::SETS][cache_types::WAYS];
  logic                             ref_valid [cache_types::SETS][cache_types::WAYS];
  cache_types::plru_state_t         ref_tree [cache_types::SETS];

  cache_top dut0 (.*);

  cache_mem_model mem0 (
    .clk  (clk),
    .rst_n(rst_n),
    .cyc  (mem_cyc),
    .stb  (mem_stb),
    .we   (mem_we),
    .adr  (mem_adr),
    .dat_w(mem_dat_w),
    .dat_r(mem_dat_r),
    .ack  (mem_ack)
  );

  assign exp_word = shadow[cpu_adr[7:0]];

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic void count_error(input string msg);
    errors++;
    $display("** Error at time %0t: %s", $time, msg);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Root 0 sends the victim to ways 0 and 1
  function automatic int pick_victim(input cache_types::plru_state_t t);
    if (!t[2]) begin
      return t[1] ? 1 : 0;
    end
    return t[0] ? 3 : 2;
  endfunction

  function automatic cache_types::plru_state_t touch(input cache_types::plru_state_t t,
                                                      input int w);
    cache_types::plru_state_t n;
    n    = t;
    n[2] = (w < 2);  // Point away from the used half
    if (w < 2) begin
      n[1] = (w == 0);
    end else begin
      n[0] = (w == 2);
    end
    return n;
  endfunction

  task automatic predict(input logic we, input logic [31:0] adr, output logic hit);
    int set;
    int way;
    set = int'(adr[3:0]);
    way = -1;
    for (int w = 0; w < cache_types::WAYS; w++) begin
      if (ref_valid[set][w] && ref_tag[set][w] == adr[31:4]) begin
        way = w;
      end
    end
    hit = (way >= 0);
    if (!hit && !we) begin
      way = pick_victim(ref_tree[set]);
      for (int w = cache_types::WAYS - 1; w >= 0; w--) begin
        if (!ref_valid[set][w]) begin
          way = w;  // Empty ways before the tree
        end
      end
      ref_valid[set][way] = 1'b1;
      ref_tag[set][way]   = adr[31:4];
    end
    if (hit || !we) begin
      ref_tree[set] = touch(ref_tree[set], way);
    end
  endtask

  task automatic cpu_access(input logic we, input logic [31:0] adr, input logic [31:0] dat);
    logic hit;
    int   waited;
    predict(we, adr, hit);
    waited = 0;
    @(posedge clk);
    cpu_cyc    <= 1'b1;
    cpu_stb    <= 1'b1;
    cpu_we     <= we;
    cpu_adr    <= adr;
    cpu_dat_w  <= dat;
    expect_hit <= hit && !we;
    req_new    <= 1'b1;
    @(posedge clk);
    req_new <= 1'b0;
    do begin
      @(negedge clk);
      waited++;
    end while (!cpu_ack && waited < 40);
    if (!cpu_ack) begin
      $display("Request to address %h got no ack within 40 cycles", adr);
      $display("SIMULATION FAILED");
      $finish;
    end
    if (we) begin
      shadow[adr[7:0]] = dat;
    end
    @(posedge clk);
    cpu_cyc    <= 1'b0;
    cpu_stb    <= 1'b0;
    expect_hit <= 1'b0;
  endtask

  task automatic close_test(input string name);
    tests++;
    $display("Test %0d (%s) finished, %0d errors so far", tests, name, errors);
  endtask

  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |=> !cpu_ack && !mem_cyc && !mem_stb && !mem_we)
    else count_error("ack or memory cycle active around reset");
  a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
    cpu_ack && !cpu_we |-> cpu_dat_r == exp_word)
    else count_error($sformatf("read of %h returned %h, expected %h",
      $sampled(cpu_adr), $sampled(cpu_dat_r), $sampled(exp_word)));
  a_hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
    req_new && expect_hit |=> cpu_ack)
    else count_error($sformatf("no one-cycle ack on hit of %h", $sampled(cpu_adr)));
  a_miss_uses_mem: assert property (@(posedge clk) disable iff (!rst_n)
    req_new && !expect_hit |=> mem_cyc)
    else count_error($sformatf("no memory cycle for %h", $sampled(cpu_adr)));
  a_hit_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    expect_hit |-> !mem_cyc)
    else count_error("memory cycle during a read hit");
  a_write_through: assert property (@(posedge clk) disable iff (!rst_n)
    mem_cyc || mem_stb |-> mem_cyc && mem_stb && mem_adr == cpu_adr && mem_we == cpu_we
      && (!cpu_we || mem_dat_w == cpu_dat_w))
    else count_error("memory request differs from processor request");

  initial begin
    logic [31:0] plru_seq [11];
    logic        rw;
    errors     = 0;
    tests      = 0;
    lfsr       = 32'd69105;
    rst_n      = 1'b0;
    cpu_cyc    = 1'b0;
    cpu_stb    = 1'b0;
    cpu_we     = 1'b0;
    cpu_adr    = '0;
    cpu_dat_w  = '0;
    req_new    = 1'b0;
    expect_hit = 1'b0;
    for (int a = 0; a < 256; a++) begin
      shadow[a] = a ^ 32'hC0DE0000;
    end
    for (int s = 0; s < cache_types::SETS; s++) begin
      ref_tree[s] = '0;
      for (int w = 0; w < cache_types::WAYS; w++) begin
        ref_valid[s][w] = 1'b0;
        ref_tag[s][w]   = '0;
      end
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    cpu_access(1'b0, 32'h0A, '0);  // Cold miss
    close_test("reset");
    cpu_access(1'b0, 32'h0A, '0);
    close_test("read hit");
    cpu_access(1'b1, 32'h0A, 32'h1234_5678);
    cpu_access(1'b0, 32'h0A, '0);
    cpu_access(1'b1, 32'h3B, 32'hA5A5_0F0F);  // Miss, no allocate
    cpu_access(1'b0, 32'h3B, '0);
    close_test("write-through");

    // A B C D, hit A and C, E replaces B, then A C D hit and B misses
    plru_seq = '{32'h05, 32'h15, 32'h25, 32'h35, 32'h05, 32'h25,
                 32'h45, 32'h05, 32'h25, 32'h35, 32'h15};
    foreach (plru_seq[i]) begin
      cpu_access(1'b0, plru_seq[i], '0);
    end
    close_test("plru eviction");

    // Sets 0, 4, 8 and 12 get 16 tags each
    repeat (300) begin
      rw = take_bits(1) != 0;
      cpu_access(rw, take_bits(6) << 2, take_bits(32));
    end
    close_test("random traffic");

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: tests/cache_mem_model.sv
module cache_mem_model (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [31:0] adr,
  input  logic [31:0] dat_w,
  output logic [31:0] dat_r,
  output logic        ack
);

  logic [31:0] mem [256];
  logic [31:0] lfsr;
  logic [31:0] lfsr_1;    // One step ahead
  logic [31:0] lfsr_2;    // Two steps ahead
  logic        busy;
  logic [1:0]  wait_cnt;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  assign lfsr_1 = lfsr_next(lfsr);
  assign lfsr_2 = lfsr_next(lfsr_1);

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int a = 0; a < 256; a++) begin
        mem[a] <= a ^ 32'hC0DE0000;  // Pattern over the whole address
      end
      lfsr     <= 32'd69105;
      busy     <= 1'b0;
      wait_cnt <= 2'd0;
      ack      <= 1'b0;
      dat_r    <= '0;
    end else begin
      ack <= 1'b0;
      if (cyc && stb && !busy && !ack) begin
        busy     <= 1'b1;
        wait_cnt <= {lfsr_1[0], lfsr_2[0]};  // Two bits, two steps
        lfsr     <= lfsr_2;
      end else if (busy && wait_cnt != 2'd0) begin
        wait_cnt <= wait_cnt - 2'd1;
      end else if (busy) begin
        busy <= 1'b0;
        ack  <= 1'b1;
        if (we) begin
          mem[adr[7:0]] <= dat_w;
        end else begin
          dat_r <= mem[adr[7:0]];
        end
      end
    end
  end

endmodule

// File: hdl/cache_top.sv
module cache_top (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              cpu_cyc,
  input  logic                              cpu_stb,
  input  logic                              cpu_we,
  input  logic [cache_types::ADDR_BITS-1:0] cpu_adr,
  input  logic [cache_types::WORD_BITS-1:0] cpu_dat_w,
  output logic [cache_types::WORD_BITS-1:0] cpu_dat_r,
  output logic                              cpu_ack,
  output logic                              mem_cyc,
  output logic                              mem_stb,
  output logic                              mem_we,
  output logic [cache_types::ADDR_BITS-1:0] mem_adr,
  output logic [cache_types::WORD_BITS-1:0] mem_dat_w,
  input  logic [cache_types::WORD_BITS-1:0] mem_dat_r,
  input  logic                              mem_ack
);

  cache_types::tag_set_t             tag_set;
  cache_types::tag_set_t             tag_wdata;
  cache_types::data_set_t            data_set;
  cache_types::data_set_t            data_wdata;
  logic                              tag_we;
  logic                              data_we;
  logic                              hit;
  cache_types::way_vec_t             hit_way;
  cache_types::way_vec_t             free_way;
  cache_types::way_vec_t             evict_way;
  cache_types::way_vec_t             plru_way;
  logic [cache_types::WORD_BITS-1:0] hit_data;
  logic                              plru_update;

  ff_array_rw #(
    .payload_t(cache_types::tag_set_t)
  ) tag_array (
    .clk    (clk),
    .rst_n  (rst_n),
    .we     (tag_we),
    .set_idx(cpu_adr[cache_types::SET_BITS-1:0]),
    .wdata  (tag_wdata),
    .rdata  (tag_set)
  );

  ff_array_rw #(
    .payload_t(cache_types::data_set_t)
  ) data_array (
    .clk    (clk),
    .rst_n  (rst_n),
    .we     (data_we),
    .set_idx(cpu_adr[cache_types::SET_BITS-1:0]),
    .wdata  (data_wdata),
    .rdata  (data_set)
  );

  way_lookup lookup0 (
    .tag_set (tag_set),
    .data_set(data_set),
    .req_tag (cpu_adr[cache_types::ADDR_BITS-1:cache_types::SET_BITS]),
    .hit     (hit),
    .hit_way (hit_way),
    .hit_data(hit_data),
    .free_way(free_way)
  );

  plru plru0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .update    (plru_update),
    .set_addr  (cpu_adr[cache_types::SET_BITS-1:0]),
    .access_way(plru_way),
    .evict_way (evict_way)
  );

  cache_ctrl ctrl0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .cpu_cyc    (cpu_cyc),
    .cpu_stb    (cpu_stb),
    .cpu_we     (cpu_we),
    .cpu_adr    (cpu_adr),
    .cpu_dat_w  (cpu_dat_w),
    .cpu_dat_r  (cpu_dat_r),
    .cpu_ack    (cpu_ack),
    .mem_cyc    (mem_cyc),
    .mem_stb    (mem_stb),
    .mem_we     (mem_we),
    .mem_adr    (mem_adr),
    .mem_dat_w  (mem_dat_w),
    .mem_dat_r  (mem_dat_r),
    .mem_ack    (mem_ack),
    .hit        (hit),
    .hit_way    (hit_way),
    .hit_data   (hit_data),
    .free_way   (free_way),
    .evict_way  (evict_way),
    .tag_set    (tag_set),
    .data_set   (data_set),
    .tag_we     (tag_we),
    .tag_wdata  (tag_wdata),
    .data_we    (data_we),
    .data_wdata (data_wdata),
    .plru_update(plru_update),
    .plru_way   (plru_way)
  );

endmodule

// File: hdl/cache_ctrl.sv
module cache_ctrl (
  input  logic                              clk,
  input  logic                              rst_n,
  // Processor side
  input  logic                              cpu_cyc,
  input  logic                              cpu_stb,
  input  logic                              cpu_we,
  input  logic [cache_types::ADDR_BITS-1:0] cpu_adr,
  input  logic [cache_types::WORD_BITS-1:0] cpu_dat_w,
  output logic [cache_types::WORD_BITS-1:0] cpu_dat_r,
  output logic                              cpu_ack,
  // Memory side
  output logic                              mem_cyc,
  output logic                              mem_stb,
  output logic                              mem_we,
  output logic [cache_types::ADDR_BITS-1:0] mem_adr,
  output logic [cache_types::WORD_BITS-1:0] mem_dat_w,
  input  logic [cache_types::WORD_BITS-1:0] mem_dat_r,
  input  logic                              mem_ack,
  // Lookup and replacement
  input  logic                              hit,
  input  cache_types::way_vec_t             hit_way,
  input  logic [cache_types::WORD_BITS-1:0] hit_data,
  input  cache_types::way_vec_t             free_way,
  input  cache_types::way_vec_t             evict_way,
  input  cache_types::tag_set_t             tag_set,
  input  cache_types::data_set_t            data_set,
  // Array writes
  output logic                              tag_we,
  output cache_types::tag_set_t             tag_wdata,
  output logic                              data_we,
  output cache_types::data_set_t            data_wdata,
  output logic                              plru_update,
  output cache_types::way_vec_t             plru_way
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_MEM,
    ST_RESP
  } state_t;

  state_t                            state;
  state_t                            state_nxt;
  logic                              req_hit;    // Write hit seen at request time
  cache_types::way_vec_t             req_way;    // Hit way or fill way
  logic [cache_types::WORD_BITS-1:0] rdata_q;

  logic                              cpu_req;
  logic                              new_req;
  logic                              mem_done;
  cache_types::way_vec_t             fill_way;
  cache_types::tag_entry_t           new_entry;

  assign cpu_req  = cpu_cyc && cpu_stb;
  assign new_req  = (state == ST_IDLE) && cpu_req;
  assign mem_done = (state == ST_MEM) && mem_ack;
  assign fill_way = (free_way != '0) ? free_way : evict_way;  // Invalid ways first

  // Master holds its request, so the memory cycle reuses it as is
  assign mem_cyc   = (state == ST_MEM);
  assign mem_stb   = (state == ST_MEM);
  assign mem_we    = (state == ST_MEM) && cpu_we;
  assign mem_adr   = cpu_adr;
  assign mem_dat_w = cpu_dat_w;

  assign cpu_ack   = (state == ST_RESP);
  assign cpu_dat_r = rdata_q;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (cpu_req) begin
          state_nxt = (!cpu_we && hit) ? ST_RESP : ST_MEM;
        end
      end
      ST_MEM: begin
        if (mem_ack) begin
          state_nxt = ST_RESP;
        end
      end
      ST_RESP: state_nxt = ST_IDLE;  // Ack lasts one cycle
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= ST_IDLE;
      req_hit <= 1'b0;
      req_way <= '0;
    end else begin
      state <= state_nxt;
      if (new_req) begin
        req_hit <= hit;
        req_way <= cpu_we ? hit_way : fill_way;
      end
    end
  end

  // Returned word, from the set on a hit or from the bus on a fill
  always_ff @(posedge clk) begin
    if (new_req && !cpu_we) begin
      rdata_q <= hit_data;
    end else if (mem_done && !cpu_we) begin
      rdata_q <= mem_dat_r;
    end
  end

  assign new_entry = {1'b1, cpu_adr[cache_types::ADDR_BITS-1:cache_types::SET_BITS]};

  // New sets differ from the current ones in the latched way only
  always_comb begin
    tag_we      = 1'b0;
    data_we     = 1'b0;
    plru_update = 1'b0;
    plru_way    = req_way;
    tag_wdata   = tag_set;
    data_wdata  = data_set;
    for (int i = 0; i < cache_types::WAYS; i++) begin
      if (req_way[i]) begin
        tag_wdata[i]  = new_entry;
        data_wdata[i] = cpu_we ? cpu_dat_w : mem_dat_r;
      end
    end
    if (new_req && !cpu_we && hit) begin
      plru_update = 1'b1;  // Read hit
      plru_way    = hit_way;
    end else if (mem_done && !cpu_we) begin
      tag_we      = 1'b1;  // Fill
      data_we     = 1'b1;
      plru_update = 1'b1;
    end else if (mem_done && req_hit) begin
      data_we     = 1'b1;  // Write hit patch
      plru_update = 1'b1;
    end
  end

  // Relies on the processor holding its request through the memory cycle
  a_mem_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    mem_stb && !mem_ack |=> $stable({mem_cyc, mem_stb, mem_we, mem_adr, mem_dat_w})
  ) else $error("memory request changed before ack");

endmodule

// File: hdl/way_lookup.sv
module way_lookup (
  input  cache_types::tag_set_t             tag_set,
  input  cache_types::data_set_t            data_set,
  input  logic [cache_types::TAG_BITS-1:0]  req_tag,
  output logic                              hit,
  output cache_types::way_vec_t             hit_way,
  output logic [cache_types::WORD_BITS-1:0] hit_data,
  output cache_types::way_vec_t             free_way
);

  // Tag compare, only valid ways count
  always_comb begin
    for (int i = 0; i < cache_types::WAYS; i++) begin
      hit_way[i] = tag_set[i].valid && (tag_set[i].tag == req_tag);
    end
  end

  assign hit = |hit_way;

  // AND-OR mux over the ways
  always_comb begin
    hit_data = '0;
    for (int i = 0; i < cache_types::WAYS; i++) begin
      if (hit_way[i]) begin
        hit_data = hit_data | data_set[i];
      end
    end
  end

  // Lowest invalid way wins, zero when the set is full
  always_comb begin
    free_way = '0;
    for (int i = cache_types::WAYS - 1; i >= 0; i--) begin
      if (!tag_set[i].valid) begin
        free_way    = '0;
        free_way[i] = 1'b1;
      end
    end
  end

  // Fills never duplicate a tag that is already present in the set
  always_comb begin
    if (!$isunknown(hit_way)) begin
      a_hit_onehot0: assert ($onehot0(hit_way))
        else $error("tag matches in more than one way");
    end
  end

endmodule

// File: hdl/plru.sv
module plru (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             update,
  input  logic [cache_types::SET_BITS-1:0] set_addr,
  input  cache_types::way_vec_t            access_way,
  output cache_types::way_vec_t            evict_way
);

  cache_types::plru_state_t         plru_state;
  cache_types::plru_state_t         plru_new_state;
  logic [cache_types::WAY_BITS-1:0] access_idx;
  logic [cache_types::WAY_BITS-1:0] evict_idx;

  // One-hot encoder
  always_comb begin
    access_idx = '0;
    for (int i = 0; i < cache_types::WAYS; i++) begin
      if (access_way[i]) begin
        access_idx = i[cache_types::WAY_BITS-1:0];
      end
    end
  end

  // Walk from the root along the accessed way's path
  always_comb begin
    int unsigned node;
    logic        dir;
    plru_new_state = plru_state;  // Nodes off the path keep their bits
    node = 0;
    for (int lvl = 0; lvl < cache_types::WAY_BITS; lvl++) begin
      dir = access_idx[cache_types::WAY_BITS-1-lvl];  // 0 = lower half
      plru_new_state[cache_types::PLRU_BITS-1-node] = ~dir;  // Point away
      node = 2 * node + 1 + dir;
    end
  end

  // Follow the stored bits down to the victim leaf
  always_comb begin
    int unsigned node;
    logic        dir;
    evict_idx = '0;
    node = 0;
    for (int lvl = 0; lvl < cache_types::WAY_BITS; lvl++) begin
      dir = plru_state[cache_types::PLRU_BITS-1-node];
      evict_idx[cache_types::WAY_BITS-1-lvl] = dir;
      node = 2 * node + 1 + dir;
    end
  end

  // Leaf index to one-hot candidate
  always_comb begin
    evict_way = '0;
    evict_way[evict_idx] = 1'b1;
  end

  ff_array_rw #(
    .payload_t(cache_types::plru_state_t)
  ) plru_array (
    .clk    (clk),
    .rst_n  (rst_n),
    .we     (update),
    .set_idx(set_addr),
    .wdata  (plru_new_state),
    .rdata  (plru_state)
  );

  // A way just touched is never the next victim of its set
  a_evict_not_recent: assert property (
    @(posedge clk) disable iff (!rst_n)
    update |=> (set_addr != $past(set_addr)) || ((evict_way & $past(access_way)) == '0)
  ) else $error("PLRU candidate is the way just accessed");

  // The controller must name exactly one way on every update
  a_access_onehot: assert property (
    @(posedge clk) disable iff (!rst_n)
    update |-> $onehot(access_way)
  ) else $error("PLRU update without a single accessed way");

endmodule

// File: hdl/ff_array_rw.sv
module ff_array_rw #(
  parameter type payload_t = logic
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             we,
  input  logic [cache_types::SET_BITS-1:0] set_idx,
  input  payload_t                         wdata,
  output payload_t                         rdata
);

  // One payload per set
  payload_t entries [cache_types::SETS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Clears valid bits and tree state
      for (int i = 0; i < cache_types::SETS; i++) begin
        entries[i] <= '0;
      end
    end else if (we) begin
      entries[set_idx] <= wdata;
    end
  end

  assign rdata = entries[set_idx];  // Asynchronous read

  // Index comes straight from the processor address
  a_set_idx_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    we |-> !$isunknown(set_idx)
  ) else $error("array write with unknown set index");

endmodule

// File: hdl/cache_types.sv
package cache_types;

  // Cache geometry
  localparam int WAYS      = 4;
  localparam int WAY_BITS  = $clog2(WAYS);
  localparam int SETS      = 16;
  localparam int SET_BITS  = $clog2(SETS);
  localparam int WORD_BITS = 32;

  // Word address split as {tag, set}
  localparam int ADDR_BITS = 32;
  localparam int TAG_BITS  = ADDR_BITS - SET_BITS;

  // Tree nodes, root first
  localparam int PLRU_BITS = WAYS - 1;

  typedef struct packed {
    logic                valid;
    logic [TAG_BITS-1:0] tag;
  } tag_entry_t;

  // One entry per way, way 0 in the low slice
  typedef tag_entry_t [WAYS-1:0] tag_set_t;

  typedef logic [WAYS-1:0][WORD_BITS-1:0] data_set_t;

  // Bit PLRU_BITS-1 is the root node
  typedef logic [PLRU_BITS-1:0] plru_state_t;

  typedef logic [WAYS-1:0] way_vec_t;  // One-hot or zero

endpackage
